// ==== tb.f ====
src/axil_pkg.sv
src/axil_reg_slice.sv
src/axil_ram.sv
src/axil_bank_decoder.sv
src/axil_mem_sys.sv
verif/axil_mem_sys_properties.sv
verif/tb_axil_mem_sys.sv

// ==== verif/tb_axil_mem_sys.sv ====
/*
 * Testbench for the two-bank AXI4-Lite memory: directed tests against a
 * reference word model, with response back-pressure and random traffic
 */
`timescale 1ns/1ps

module tb_axil_mem_sys
   import axil_pkg::*;
();

   // handshake timeout in clock cycles
   localparam int max_wait = 64;

   logic clk;
   logic rst;
   axil_aw_t s_aw;
   logic s_aw_valid;
   logic s_aw_ready;
   axil_w_t s_w;
   logic s_w_valid;
   logic s_w_ready;
   axil_b_t s_b;
   logic s_b_valid;
   logic s_b_ready;
   axil_ar_t s_ar;
   logic s_ar_valid;
   logic s_ar_ready;
   axil_r_t s_r;
   logic s_r_valid;
   logic s_r_ready;
   logic [dbg_addr_width-1:0] dbg_rd_addr;
   logic [data_width-1:0] dbg_rd_data;
   dbg_wr_t dbg_wr;

   // reference words indexed by bank bit and word address
   logic [data_width-1:0] model [2*bank_words];
   logic [31:0] lfsr_state;
   string cur_test;
   int errors;
   int errors_at_start;
   int tests_run;
   int tests_failed;

   axil_mem_sys u_axil_mem_sys (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // taps of x^32 + x^22 + x^2 + x + 1 with one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // built from the full word index so every word differs
   function automatic logic [data_width-1:0] fill_word(input logic [dbg_addr_width-1:0] idx);
      return {idx, 4'h9, ~idx};
   endfunction

   task automatic check_resp(input string name, input axil_b_t exp, input axil_b_t act);
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: b expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_rdata(input string name, input axil_r_t exp, input axil_r_t act);
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: r expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_dbg(input string name, input logic [data_width-1:0] exp,
                            input logic [data_width-1:0] act);
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: debug data expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input string what, input logic exp,
                            input logic act);
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: %s expected %b actual %b", name, what, exp, act);
      end
   endtask

   task automatic print_counts();
      $display("summary: %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
               tests_run, tests_failed, errors, u_axil_mem_sys.u_properties.fail_count);
   endtask

   task automatic give_up(input string what);
      $display("timeout in %s: the %s never completed", cur_test, what);
      print_counts();
      $display("Test failures found");
      $finish;
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors != errors_at_start) begin
         tests_failed++;
      end
      $display("test %-12s %s", cur_test, (errors == errors_at_start) ? "ok" : "FAILED");
   endtask

   // aw and w together then b held off for delay cycles
   task automatic axi_write(input logic [addr_width-1:0] byte_addr,
                            input logic [data_width-1:0] data,
                            input logic [strb_width-1:0] strb, input int delay);
      axil_b_t exp_b;
      logic aw_go;
      logic w_go;
      int waited;
      exp_b.resp = axil_resp_okay;
      s_aw = '{addr: byte_addr, prot: 3'b000};
      s_w = '{data: data, strb: strb};
      s_aw_valid = 1'b1;
      s_w_valid = 1'b1;
      waited = 0;
      // ready seen at the falling edge holds through the next rising edge
      while ((s_aw_valid || s_w_valid) && waited < max_wait) begin
         aw_go = s_aw_valid && s_aw_ready;
         w_go = s_w_valid && s_w_ready;
         @(negedge clk);
         if (aw_go) s_aw_valid = 1'b0;
         if (w_go) s_w_valid = 1'b0;
         waited++;
      end
      if (s_aw_valid || s_w_valid) give_up("write address and data handshake");
      // lane by lane into the model
      for (int i = 0; i < strb_width; i++) begin
         if (strb[i]) model[byte_addr[addr_width-1:2]][8*i +: 8] = data[8*i +: 8];
      end
      waited = 0;
      while (!s_b_valid && waited < max_wait) begin
         @(negedge clk);
         waited++;
      end
      if (!s_b_valid) give_up("write response");
      check_resp(cur_test, exp_b, s_b);
      repeat (delay) @(negedge clk);
      s_b_ready = 1'b1;
      check_bit(cur_test, "b_valid at transfer", 1'b1, s_b_valid);
      check_resp(cur_test, exp_b, s_b);
      @(negedge clk);
      s_b_ready = 1'b0;
   endtask

   task automatic axi_read(input logic [addr_width-1:0] byte_addr, input int delay);
      axil_r_t exp_r;
      int waited;
      exp_r.data = model[byte_addr[addr_width-1:2]];
      exp_r.resp = axil_resp_okay;
      s_ar = '{addr: byte_addr, prot: 3'b000};
      s_ar_valid = 1'b1;
      waited = 0;
      while (!s_ar_ready && waited < max_wait) begin
         @(negedge clk);
         waited++;
      end
      if (!s_ar_ready) give_up("read address handshake");
      @(negedge clk);
      s_ar_valid = 1'b0;
      waited = 0;
      while (!s_r_valid && waited < max_wait) begin
         @(negedge clk);
         waited++;
      end
      if (!s_r_valid) give_up("read response");
      check_rdata(cur_test, exp_r, s_r);
      repeat (delay) @(negedge clk);
      s_r_ready = 1'b1;
      check_bit(cur_test, "r_valid at transfer", 1'b1, s_r_valid);
      check_rdata(cur_test, exp_r, s_r);
      @(negedge clk);
      s_r_ready = 1'b0;
   endtask

   task automatic dbg_write(input logic [dbg_addr_width-1:0] idx,
                            input logic [data_width-1:0] data);
      dbg_wr = '{en: 1'b1, addr: idx, data: data};
      model[idx] = data;
      @(negedge clk);
      dbg_wr.en = 1'b0;
   endtask

   task automatic dbg_check(input logic [dbg_addr_width-1:0] idx);
      dbg_rd_addr = idx;
      @(negedge clk);
      check_dbg(cur_test, model[idx], dbg_rd_data);
   endtask

   task automatic fill_memory();
      for (int i = 0; i < 2*bank_words; i++) begin
         dbg_write(i[dbg_addr_width-1:0], fill_word(i[dbg_addr_width-1:0]));
      end
   endtask

   task automatic test_reset_state();
      start_test("reset_state");
      // slices stay closed for the first cycle out of reset
      check_bit(cur_test, "b_valid", 1'b0, s_b_valid);
      check_bit(cur_test, "r_valid", 1'b0, s_r_valid);
      check_bit(cur_test, "aw_ready", 1'b0, s_aw_ready);
      check_bit(cur_test, "w_ready", 1'b0, s_w_ready);
      check_bit(cur_test, "ar_ready", 1'b0, s_ar_ready);
      dbg_write(14'h0040, 32'hc0ffee01);
      axi_read(16'h0100, 0);
      end_test();
   endtask

   task automatic test_bank_rw();
      start_test("bank_rw");
      axi_write(16'h0010, 32'h0badf00d, 4'hf, 0);
      axi_write(16'h8010, 32'h5eed1e55, 4'hf, 0);
      // same offset in both banks
      axi_read(16'h0010, 0);
      axi_read(16'h8010, 0);
      end_test();
   endtask

   task automatic test_strobes();
      start_test("strobes");
      for (int bank = 0; bank < 2; bank++) begin
         axi_write({bank[0], 15'h0200}, 32'hffffffff, 4'hf, 0);
         for (int s = 1; s < 15; s += 3) begin
            axi_write({bank[0], 15'h0200}, 32'h01234567 + s, s[3:0], 0);
            axi_read({bank[0], 15'h0200}, 0);
         end
      end
      end_test();
   endtask

   task automatic test_debug();
      start_test("debug");
      for (int bank = 0; bank < 2; bank++) begin
         dbg_write({bank[0], 13'h0123}, 32'hdb600000 | bank);
         axi_read({bank[0], 13'h0123, 2'b00}, 0);
         axi_write({bank[0], 13'h0456, 2'b00}, 32'hacce5500 | bank, 4'hf, 0);
         dbg_check({bank[0], 13'h0456});
      end
      end_test();
   endtask

   task automatic test_backpressure();
      logic [dbg_addr_width-1:0] idx;
      logic [data_width-1:0] data;
      start_test("backpressure");
      for (int n = 0; n < 8; n++) begin
         idx = take_bits(dbg_addr_width);
         data = take_bits(data_width);
         axi_write({idx, 2'b00}, data, 4'hf, take_bits(4));
         axi_read({idx, 2'b00}, take_bits(4));
      end
      end_test();
   endtask

   task automatic test_random();
      logic [dbg_addr_width-1:0] idx;
      logic [data_width-1:0] data;
      logic [strb_width-1:0] strb;
      start_test("random");
      for (int n = 0; n < 200; n++) begin
         idx = take_bits(dbg_addr_width);
         if (take_bits(1) == 1) begin
            strb = take_bits(strb_width);
            data = take_bits(data_width);
            axi_write({idx, 2'b00}, data, strb, 0);
         end else begin
            axi_read({idx, 2'b00}, 0);
         end
      end
      end_test();
   endtask

   initial begin
      rst = 1'b1;
      s_aw = '0;
      s_aw_valid = 1'b0;
      s_w = '0;
      s_w_valid = 1'b0;
      s_b_ready = 1'b0;
      s_ar = '0;
      s_ar_valid = 1'b0;
      s_r_ready = 1'b0;
      dbg_rd_addr = '0;
      dbg_wr = '0;
      lfsr_state = 32'hd852cde8;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      test_reset_state();
      fill_memory();
      test_bank_rw();
      test_strobes();
      test_debug();
      test_backpressure();
      test_random();
      print_counts();
      if (errors == 0 && u_axil_mem_sys.u_properties.fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== verif/axil_mem_sys_properties.sv ====
/*
 * Bound checks on the memory's response ports and its reset state
 */
`timescale 1ns/1ps

module axil_mem_sys_properties
   import axil_pkg::*;
(
   input logic    clk,
   input logic    rst,
   input axil_b_t s_b,
   input logic    s_b_valid,
   input logic    s_b_ready,
   input axil_r_t s_r,
   input logic    s_r_valid,
   input logic    s_r_ready,
   input logic    s_aw_ready,
   input logic    s_w_ready,
   input logic    s_ar_ready
);

   // assertion failure count
   int fail_count = 0;

   // stalled responses keep valid and payload
   b_held: assert property (@(posedge clk) disable iff (rst)
      s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b))
      else begin
         $error("write response dropped or changed while stalled");
         fail_count++;
      end

   r_held: assert property (@(posedge clk) disable iff (rst)
      s_r_valid && !s_r_ready |=> s_r_valid && $stable(s_r))
      else begin
         $error("read response dropped or changed while stalled");
         fail_count++;
      end

   b_okay: assert property (@(posedge clk) disable iff (rst)
      s_b_valid |-> s_b.resp == axil_resp_okay)
      else begin
         $error("write response not OKAY");
         fail_count++;
      end

   r_okay: assert property (@(posedge clk) disable iff (rst)
      s_r_valid |-> s_r.resp == axil_resp_okay)
      else begin
         $error("read response not OKAY");
         fail_count++;
      end

   // first edge out of reset, all handshake outputs quiet
   reset_quiet: assert property (@(posedge clk)
      $fell(rst) |-> !(s_aw_ready || s_w_ready || s_ar_ready || s_b_valid || s_r_valid))
      else begin
         $error("valid or ready output high right after reset");
         fail_count++;
      end

endmodule

bind axil_mem_sys axil_mem_sys_properties u_properties (
   .clk(clk),
   .rst(rst),
   .s_b(s_b),
   .s_b_valid(s_b_valid),
   .s_b_ready(s_b_ready),
   .s_r(s_r),
   .s_r_valid(s_r_valid),
   .s_r_ready(s_r_ready),
   .s_aw_ready(s_aw_ready),
   .s_w_ready(s_w_ready),
   .s_ar_ready(s_ar_ready)
);

// ==== src/axil_mem_sys.sv ====
/*
 * Two-bank AXI4-Lite memory: sliced channels, bank decoder, two RAMs
 */
`timescale 1ns/1ps

module axil_mem_sys
   import axil_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  axil_aw_t                  s_aw,
   input  logic                      s_aw_valid,
   output logic                      s_aw_ready,
   input  axil_w_t                   s_w,
   input  logic                      s_w_valid,
   output logic                      s_w_ready,
   output axil_b_t                   s_b,
   output logic                      s_b_valid,
   input  logic                      s_b_ready,
   input  axil_ar_t                  s_ar,
   input  logic                      s_ar_valid,
   output logic                      s_ar_ready,
   output axil_r_t                   s_r,
   output logic                      s_r_valid,
   input  logic                      s_r_ready,
   input  logic [dbg_addr_width-1:0] dbg_rd_addr,
   output logic [data_width-1:0]     dbg_rd_data,
   input  dbg_wr_t                   dbg_wr
);

   // between the slices and the decoder
   axil_aw_t aw_q;
   axil_w_t w_q;
   axil_ar_t ar_q;
   axil_b_t b_d;
   axil_r_t r_d;
   logic aw_q_valid, aw_q_ready, w_q_valid, w_q_ready, ar_q_valid, ar_q_ready;
   logic b_d_valid, b_d_ready, r_d_valid, r_d_ready;

   // decoder to banks
   axil_aw_t m0_aw, m1_aw;
   axil_w_t m0_w, m1_w;
   axil_b_t m0_b, m1_b;
   axil_ar_t m0_ar, m1_ar;
   axil_r_t m0_r, m1_r;
   logic m0_aw_valid, m0_aw_ready, m0_w_valid, m0_w_ready, m0_b_valid, m0_b_ready;
   logic m0_ar_valid, m0_ar_ready, m0_r_valid, m0_r_ready;
   logic m1_aw_valid, m1_aw_ready, m1_w_valid, m1_w_ready, m1_b_valid, m1_b_ready;
   logic m1_ar_valid, m1_ar_ready, m1_r_valid, m1_r_ready;
   logic [word_addr_width-1:0] dbg0_rd_addr, dbg1_rd_addr;
   logic [data_width-1:0] dbg0_rd_data, dbg1_rd_data;
   dbg_wr_t dbg0_wr, dbg1_wr;

   // request slices in, response slices out
   axil_reg_slice #(.payload_t(axil_aw_t)) u_aw_slice (
      .clk, .rst, .in_data(s_aw), .in_valid(s_aw_valid), .in_ready(s_aw_ready),
      .out_data(aw_q), .out_valid(aw_q_valid), .out_ready(aw_q_ready));

   axil_reg_slice #(.payload_t(axil_w_t)) u_w_slice (
      .clk, .rst, .in_data(s_w), .in_valid(s_w_valid), .in_ready(s_w_ready),
      .out_data(w_q), .out_valid(w_q_valid), .out_ready(w_q_ready));

   axil_reg_slice #(.payload_t(axil_ar_t)) u_ar_slice (
      .clk, .rst, .in_data(s_ar), .in_valid(s_ar_valid), .in_ready(s_ar_ready),
      .out_data(ar_q), .out_valid(ar_q_valid), .out_ready(ar_q_ready));

   axil_reg_slice #(.payload_t(axil_b_t)) u_b_slice (
      .clk, .rst, .in_data(b_d), .in_valid(b_d_valid), .in_ready(b_d_ready),
      .out_data(s_b), .out_valid(s_b_valid), .out_ready(s_b_ready));

   axil_reg_slice #(.payload_t(axil_r_t)) u_r_slice (
      .clk, .rst, .in_data(r_d), .in_valid(r_d_valid), .in_ready(r_d_ready),
      .out_data(s_r), .out_valid(s_r_valid), .out_ready(s_r_ready));

   axil_bank_decoder u_decoder (
      .clk, .rst,
      .s_aw(aw_q), .s_aw_valid(aw_q_valid), .s_aw_ready(aw_q_ready),
      .s_w(w_q), .s_w_valid(w_q_valid), .s_w_ready(w_q_ready),
      .s_b(b_d), .s_b_valid(b_d_valid), .s_b_ready(b_d_ready),
      .s_ar(ar_q), .s_ar_valid(ar_q_valid), .s_ar_ready(ar_q_ready),
      .s_r(r_d), .s_r_valid(r_d_valid), .s_r_ready(r_d_ready),
      .m0_aw, .m0_aw_valid, .m0_aw_ready, .m0_w, .m0_w_valid, .m0_w_ready,
      .m0_b, .m0_b_valid, .m0_b_ready, .m0_ar, .m0_ar_valid, .m0_ar_ready,
      .m0_r, .m0_r_valid, .m0_r_ready,
      .m1_aw, .m1_aw_valid, .m1_aw_ready, .m1_w, .m1_w_valid, .m1_w_ready,
      .m1_b, .m1_b_valid, .m1_b_ready, .m1_ar, .m1_ar_valid, .m1_ar_ready,
      .m1_r, .m1_r_valid, .m1_r_ready,
      .dbg_rd_addr, .dbg_rd_data, .dbg_wr,
      .dbg0_rd_addr, .dbg0_rd_data, .dbg0_wr,
      .dbg1_rd_addr, .dbg1_rd_data, .dbg1_wr);

   // bank 0, addresses 0x0000 to 0x7fff
   axil_ram u_bank0 (
      .clk, .rst,
      .aw(m0_aw), .aw_valid(m0_aw_valid), .aw_ready(m0_aw_ready),
      .w(m0_w), .w_valid(m0_w_valid), .w_ready(m0_w_ready),
      .b(m0_b), .b_valid(m0_b_valid), .b_ready(m0_b_ready),
      .ar(m0_ar), .ar_valid(m0_ar_valid), .ar_ready(m0_ar_ready),
      .r(m0_r), .r_valid(m0_r_valid), .r_ready(m0_r_ready),
      .dbg_rd_addr(dbg0_rd_addr), .dbg_rd_data(dbg0_rd_data), .dbg_wr(dbg0_wr));

   // bank 1, addresses 0x8000 to 0xffff
   axil_ram u_bank1 (
      .clk, .rst,
      .aw(m1_aw), .aw_valid(m1_aw_valid), .aw_ready(m1_aw_ready),
      .w(m1_w), .w_valid(m1_w_valid), .w_ready(m1_w_ready),
      .b(m1_b), .b_valid(m1_b_valid), .b_ready(m1_b_ready),
      .ar(m1_ar), .ar_valid(m1_ar_valid), .ar_ready(m1_ar_ready),
      .r(m1_r), .r_valid(m1_r_valid), .r_ready(m1_r_ready),
      .dbg_rd_addr(dbg1_rd_addr), .dbg_rd_data(dbg1_rd_data), .dbg_wr(dbg1_wr));

endmodule

// ==== src/axil_bank_decoder.sv ====
/*
 * Bank decoder: routes AXI4-Lite channels and the debug port to one of
 * two banks by the top address bit, one transaction per direction
 */
`timescale 1ns/1ps

module axil_bank_decoder
   import axil_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   // upstream side
   input  axil_aw_t                   s_aw,
   input  logic                       s_aw_valid,
   output logic                       s_aw_ready,
   input  axil_w_t                    s_w,
   input  logic                       s_w_valid,
   output logic                       s_w_ready,
   output axil_b_t                    s_b,
   output logic                       s_b_valid,
   input  logic                       s_b_ready,
   input  axil_ar_t                   s_ar,
   input  logic                       s_ar_valid,
   output logic                       s_ar_ready,
   output axil_r_t                    s_r,
   output logic                       s_r_valid,
   input  logic                       s_r_ready,
   // bank 0
   output axil_aw_t                   m0_aw,
   output logic                       m0_aw_valid,
   input  logic                       m0_aw_ready,
   output axil_w_t                    m0_w,
   output logic                       m0_w_valid,
   input  logic                       m0_w_ready,
   input  axil_b_t                    m0_b,
   input  logic                       m0_b_valid,
   output logic                       m0_b_ready,
   output axil_ar_t                   m0_ar,
   output logic                       m0_ar_valid,
   input  logic                       m0_ar_ready,
   input  axil_r_t                    m0_r,
   input  logic                       m0_r_valid,
   output logic                       m0_r_ready,
   // bank 1
   output axil_aw_t                   m1_aw,
   output logic                       m1_aw_valid,
   input  logic                       m1_aw_ready,
   output axil_w_t                    m1_w,
   output logic                       m1_w_valid,
   input  logic                       m1_w_ready,
   input  axil_b_t                    m1_b,
   input  logic                       m1_b_valid,
   output logic                       m1_b_ready,
   output axil_ar_t                   m1_ar,
   output logic                       m1_ar_valid,
   input  logic                       m1_ar_ready,
   input  axil_r_t                    m1_r,
   input  logic                       m1_r_valid,
   output logic                       m1_r_ready,
   // debug, top side then bank side
   input  logic [dbg_addr_width-1:0]  dbg_rd_addr,
   output logic [data_width-1:0]      dbg_rd_data,
   input  dbg_wr_t                    dbg_wr,
   output logic [word_addr_width-1:0] dbg0_rd_addr,
   input  logic [data_width-1:0]      dbg0_rd_data,
   output dbg_wr_t                    dbg0_wr,
   output logic [word_addr_width-1:0] dbg1_rd_addr,
   input  logic [data_width-1:0]      dbg1_rd_data,
   output dbg_wr_t                    dbg1_wr
);

   // route locks, held from request transfer to response transfer
   logic wr_busy;
   logic wr_bank;
   logic rd_busy;
   logic rd_bank;
   logic wr_sel;
   logic rd_sel;
   logic wr_req;
   logic rd_req;
   axil_aw_t aw_bank;
   axil_ar_t ar_bank;
   dbg_wr_t dbg_bank_wr;

   assign wr_sel = s_aw.addr[addr_width-1];
   assign rd_sel = s_ar.addr[addr_width-1];
   // write needs both halves, blocked while a response is owed
   assign wr_req = s_aw_valid && s_w_valid && !wr_busy;
   assign rd_req = s_ar_valid && !rd_busy;

   // bank sees an in-bank address
   always_comb begin
      aw_bank = s_aw;
      aw_bank.addr[addr_width-1] = 1'b0;
      ar_bank = s_ar;
      ar_bank.addr[addr_width-1] = 1'b0;
   end

   assign m0_aw = aw_bank;
   assign m1_aw = aw_bank;
   assign m0_w = s_w;
   assign m1_w = s_w;
   assign m0_ar = ar_bank;
   assign m1_ar = ar_bank;

   assign m0_aw_valid = wr_req && !wr_sel;
   assign m0_w_valid = wr_req && !wr_sel;
   assign m1_aw_valid = wr_req && wr_sel;
   assign m1_w_valid = wr_req && wr_sel;
   assign m0_ar_valid = rd_req && !rd_sel;
   assign m1_ar_valid = rd_req && rd_sel;

   assign s_aw_ready = !wr_busy && (wr_sel ? m1_aw_ready : m0_aw_ready);
   assign s_w_ready = !wr_busy && (wr_sel ? m1_w_ready : m0_w_ready);
   assign s_ar_ready = !rd_busy && (rd_sel ? m1_ar_ready : m0_ar_ready);

   // responses only from the locked bank
   assign s_b = wr_bank ? m1_b : m0_b;
   assign s_b_valid = wr_busy && (wr_bank ? m1_b_valid : m0_b_valid);
   assign m0_b_ready = wr_busy && !wr_bank && s_b_ready;
   assign m1_b_ready = wr_busy && wr_bank && s_b_ready;

   assign s_r = rd_bank ? m1_r : m0_r;
   assign s_r_valid = rd_busy && (rd_bank ? m1_r_valid : m0_r_valid);
   assign m0_r_ready = rd_busy && !rd_bank && s_r_ready;
   assign m1_r_ready = rd_busy && rd_bank && s_r_ready;

   // request and response transfers never share a cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_busy <= 1'b0;
         wr_bank <= 1'b0;
         rd_busy <= 1'b0;
         rd_bank <= 1'b0;
      end else begin
         if (s_aw_valid && s_aw_ready) begin
            wr_busy <= 1'b1;
            wr_bank <= wr_sel;
         end else if (s_b_valid && s_b_ready) begin
            wr_busy <= 1'b0;
         end
         if (s_ar_valid && s_ar_ready) begin
            rd_busy <= 1'b1;
            rd_bank <= rd_sel;
         end else if (s_r_valid && s_r_ready) begin
            rd_busy <= 1'b0;
         end
      end
   end

   // debug read mux on the bank bit
   assign dbg0_rd_addr = dbg_rd_addr[word_addr_width-1:0];
   assign dbg1_rd_addr = dbg_rd_addr[word_addr_width-1:0];
   assign dbg_rd_data = dbg_rd_addr[word_addr_width] ? dbg1_rd_data : dbg0_rd_data;

   // debug write goes to one bank, bank bit cleared
   always_comb begin
      dbg_bank_wr = dbg_wr;
      dbg_bank_wr.addr[word_addr_width] = 1'b0;
      dbg0_wr = dbg_bank_wr;
      dbg0_wr.en = dbg_wr.en && !dbg_wr.addr[word_addr_width];
      dbg1_wr = dbg_bank_wr;
      dbg1_wr.en = dbg_wr.en && dbg_wr.addr[word_addr_width];
   end

endmodule

// ==== src/axil_ram.sv ====
/*
 * AXI4-Lite single-bank RAM with byte strobes, one-cycle ready pulses
 * and a whole-word debug read/write side port
 */
`timescale 1ns/1ps

module axil_ram
   import axil_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   // write address and data
   input  axil_aw_t                   aw,
   input  logic                       aw_valid,
   output logic                       aw_ready,
   input  axil_w_t                    w,
   input  logic                       w_valid,
   output logic                       w_ready,
   // write response
   output axil_b_t                    b,
   output logic                       b_valid,
   input  logic                       b_ready,
   // read address and data
   input  axil_ar_t                   ar,
   input  logic                       ar_valid,
   output logic                       ar_ready,
   output axil_r_t                    r,
   output logic                       r_valid,
   input  logic                       r_ready,
   // debug side port
   input  logic [word_addr_width-1:0] dbg_rd_addr,
   output logic [data_width-1:0]      dbg_rd_data,
   input  dbg_wr_t                    dbg_wr
);

   logic [data_width-1:0] mem [bank_words];

   // word index from the byte address, prot ignored
   logic [word_addr_width-1:0] wr_idx;
   logic [word_addr_width-1:0] rd_idx;

   logic wr_en;
   logic rd_en;
   // ready pulses, one flop per direction
   logic wr_ack;
   logic rd_ack;
   logic b_pend;
   logic r_pend;
   logic [data_width-1:0] rdata_q;

   assign wr_idx = aw.addr[bank_addr_width-1 -: word_addr_width];
   assign rd_idx = ar.addr[bank_addr_width-1 -: word_addr_width];

   // accept: both halves valid, b slot free, no accept last cycle
   assign wr_en = aw_valid && w_valid && (!b_pend || b_ready) && !wr_ack;
   // same rule on the read side, independent of writes
   assign rd_en = ar_valid && (!r_pend || r_ready) && !rd_ack;

   assign aw_ready = wr_ack;
   assign w_ready = wr_ack;
   assign b_valid = b_pend;
   assign b = '{resp: axil_resp_okay};

   assign ar_ready = rd_ack;
   assign r_valid = r_pend;
   assign r = '{data: rdata_q, resp: axil_resp_okay};

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ack <= 1'b0;
         b_pend <= 1'b0;
         rd_ack <= 1'b0;
         r_pend <= 1'b0;
      end else begin
         wr_ack <= wr_en;
         // response held until taken
         b_pend <= wr_en || (b_pend && !b_ready);
         rd_ack <= rd_en;
         r_pend <= rd_en || (r_pend && !r_ready);
      end
   end

   // memory array, written on the accept edge
   always_ff @(posedge clk) begin
      for (int i = 0; i < strb_width; i++) begin
         if (wr_en && w.strb[i]) begin
            mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
         end
      end
      // later assignment, so debug wins a same-word collision
      if (dbg_wr.en) begin
         mem[dbg_wr.addr[word_addr_width-1:0]] <= dbg_wr.data;
      end
   end

   // read data captured with the accept
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rdata_q <= mem[rd_idx];
      end
   end

   // debug read is asynchronous
   assign dbg_rd_data = mem[dbg_rd_addr];

endmodule

// ==== src/axil_reg_slice.sv ====
/*
 * Register slice: one valid/ready stage for any channel payload,
 * full rate when the held item leaves as a new one arrives
 */
`timescale 1ns/1ps

module axil_reg_slice #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   // holding one item
   logic full;
   // low through reset and the first cycle after it
   logic armed;
   logic load;

   // room when empty, or when the held item leaves this cycle
   assign in_ready = armed && (!full || out_ready);
   assign load = in_valid && in_ready;
   assign out_valid = full;

   always_ff @(posedge clk) begin
      if (rst) begin
         armed <= 1'b0;
         full <= 1'b0;
      end else begin
         armed <= 1'b1;
         // refill or drain
         if (in_ready) begin
            full <= in_valid;
         end
      end
   end

   // payload only moves on a transfer in
   always_ff @(posedge clk) begin
      if (load) begin
         out_data <= in_data;
      end
   end

endmodule

// ==== src/axil_pkg.sv ====
/*
 * AXI4-Lite two-bank memory: shared bus widths, response code,
 * channel payload structs and the debug write struct
 */
package axil_pkg;

   // byte address and data bus widths
   localparam int addr_width = 16;
   localparam int data_width = 32;
   localparam int strb_width = data_width / 8;

   // bit 15 picks the bank, the rest addresses bytes inside it
   localparam int bank_addr_width = addr_width - 1;
   localparam int bank_words = 8192;
   localparam int word_addr_width = $clog2(bank_words);

   // debug word address, top bit is the bank
   localparam int dbg_addr_width = word_addr_width + 1;

   localparam logic [1:0] axil_resp_okay = 2'b00;

   typedef struct packed {
      logic [addr_width-1:0] addr;
      logic [2:0]            prot;
   } axil_aw_t;

   typedef struct packed {
      logic [data_width-1:0] data;
      logic [strb_width-1:0] strb;
   } axil_w_t;

   typedef struct packed {
      logic [1:0] resp;
   } axil_b_t;

   typedef struct packed {
      logic [addr_width-1:0] addr;
      logic [2:0]            prot;
   } axil_ar_t;

   typedef struct packed {
      logic [data_width-1:0] data;
      logic [1:0]            resp;
   } axil_r_t;

   // side-port word write, no handshake
   typedef struct packed {
      logic                      en;
      logic [dbg_addr_width-1:0] addr;
      logic [data_width-1:0]     data;
   } dbg_wr_t;

endpackage
